//--- Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - common
    files:
      - common/corePkg.sv
      - control/controlLogic.sv
      - logic/registerFile.sv
      - logic/executeUnit.sv
      - logic/memoryController.sv
      - logic/riscvCore.sv
      - target: test
        files:
          - test/coreProps.sv
          - test/coreTb.sv

//--- build.f
+incdir+common
common/corePkg.sv
control/controlLogic.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/memoryController.sv
logic/riscvCore.sv
test/coreProps.sv
test/coreTb.sv

//--- common/coreDefs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and address width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// First fetch address
`define RESET_VECTOR 32'h00000000

`endif

//--- common/corePkg.sv
`include "coreDefs.svh"

package corePkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0]
	{
		LUI = 7'b0110111,
		AUIPC = 7'b0010111,
		OP_IMM = 7'b0010011,
		OP = 7'b0110011,
		LOAD = 7'b0000011,
		STORE = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL = 7'b1101111,
		SYSTEM = 7'b1110011
	} Opcode_t;

	typedef enum logic [2:0] {INITIAL_WAIT, INITIAL_FETCH, FETCH_EXECUTE, EXECUTE, HALT} State_t;
	typedef enum logic [2:0] {ADD, SUB, XOR, OR, AND} AluOp_t;
	typedef enum logic [2:0] {I, S, B, U, J} ImmediateMode_t;
	typedef enum logic [2:0] {ALU, IMMEDIATE, AUIPC_SUM, LINK, MEMORY} RdSource_t; // rd write-back mux
	typedef enum logic {CURRENT_PC, NEXT_PC} InstructionAddressSource_t;
	typedef enum logic [2:0] {NONE, ECALL, BAD_OPCODE, PC_MISALIGNED, DATA_MISALIGNED} HaltCause_t;

	// Everything the FSM drives into the datapath
	typedef struct packed
	{
		logic rdWriteEnable;
		RdSource_t rdSource;
		AluOp_t aluOp;
		logic aluUseImmediate; // Second operand is the immediate, not rs2
		ImmediateMode_t immediateMode;
		logic memoryRead;
		logic memoryWrite;
		logic programCounterWriteEnable;
		InstructionAddressSource_t instructionAddressSource;
		logic isBranch; // Take pc + immediate as next PC
	} Controls_t;

	typedef struct packed
	{
		logic [`XLEN-1:0] address;
		logic [`XLEN-1:0] writeData;
		logic read;
		logic write;
	} DataRequest_t;

endpackage

//--- control/controlLogic.sv
`timescale 1ns/1ps
`include "coreDefs.svh"

module controlLogic
	import corePkg::*;
(
	input logic clock,
	input logic reset,
	input logic [31:0] instruction,
	input logic branchTaken,
	input logic pcMisaligned,
	input logic dataMisaligned,
	output Controls_t controls,
	output logic halted,
	output HaltCause_t haltCause
);

	State_t currentState, nextState;
	Opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	Controls_t decoded; // FETCH_EXECUTE controls for this instruction
	logic badOpcode;
	logic isEcall;
	logic isLoad;
	HaltCause_t faultCause;

	assign opcode = Opcode_t'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign isLoad = (opcode == LOAD);

	// Instruction decode
	always_comb
	begin
		decoded = '0;
		decoded.programCounterWriteEnable = 1'b1; // Most instructions advance
		decoded.instructionAddressSource = NEXT_PC;
		badOpcode = (instruction[1:0] != 2'b11); // Compressed or invalid encoding
		isEcall = 1'b0;
		case (opcode)
			LUI:
			begin
				decoded.rdWriteEnable = 1'b1;
				decoded.rdSource = IMMEDIATE;
				decoded.immediateMode = U;
			end
			AUIPC:
			begin
				decoded.rdWriteEnable = 1'b1;
				decoded.rdSource = AUIPC_SUM; // pc + upper immediate
				decoded.immediateMode = U;
			end
			OP_IMM, OP:
			begin
				decoded.rdWriteEnable = 1'b1;
				decoded.rdSource = ALU;
				decoded.aluUseImmediate = (opcode == OP_IMM);
				decoded.immediateMode = I;
				case ({(opcode == OP) ? funct7 : 7'b0000000, funct3})
					10'b0000000_000: decoded.aluOp = ADD;
					10'b0100000_000: decoded.aluOp = SUB; // Only reachable for OP
					10'b0000000_100: decoded.aluOp = XOR;
					10'b0000000_110: decoded.aluOp = OR;
					10'b0000000_111: decoded.aluOp = AND;
					default: badOpcode = 1'b1; // slt, shifts etc.
				endcase
			end
			LOAD:
			begin
				decoded.memoryRead = 1'b1;
				decoded.aluUseImmediate = 1'b1; // Address is rs1 + imm
				decoded.immediateMode = I;
				// Hold PC and refetch lw so EXECUTE still sees rd
				decoded.programCounterWriteEnable = 1'b0;
				decoded.instructionAddressSource = CURRENT_PC;
				badOpcode |= (funct3 != 3'b010); // lw only
			end
			STORE:
			begin
				decoded.memoryWrite = 1'b1;
				decoded.aluUseImmediate = 1'b1;
				decoded.immediateMode = S;
				badOpcode |= (funct3 != 3'b010); // sw only
			end
			BRANCH:
			begin
				decoded.immediateMode = B;
				decoded.isBranch = branchTaken; // Comparison done in executeUnit
				badOpcode |= (funct3[2:1] != 2'b00); // beq and bne
			end
			JAL:
			begin
				decoded.rdWriteEnable = 1'b1;
				decoded.rdSource = LINK;
				decoded.immediateMode = J;
				decoded.isBranch = 1'b1;
			end
			SYSTEM:
			begin
				isEcall = (instruction == 32'h00000073);
				badOpcode |= !isEcall; // No CSRs or ebreak
			end
			default: badOpcode = 1'b1;
		endcase

		// Faulting instruction has no side effects
		if (badOpcode || isEcall)
		begin
			decoded.rdWriteEnable = 1'b0;
			decoded.memoryRead = 1'b0;
			decoded.memoryWrite = 1'b0;
			decoded.isBranch = 1'b0;
			decoded.programCounterWriteEnable = 1'b0;
			decoded.instructionAddressSource = CURRENT_PC;
		end
	end

	// Halt causes only count while executing, highest priority first
	always_comb
	begin
		faultCause = NONE;
		if (currentState == FETCH_EXECUTE || currentState == EXECUTE)
		begin
			if (pcMisaligned)
				faultCause = PC_MISALIGNED;
			else if (dataMisaligned)
				faultCause = DATA_MISALIGNED;
			else if (badOpcode)
				faultCause = BAD_OPCODE;
			else if (isEcall)
				faultCause = ECALL;
		end
	end

	always_comb
	begin
		case (currentState)
			INITIAL_WAIT: nextState = INITIAL_FETCH;
			INITIAL_FETCH: nextState = FETCH_EXECUTE;
			FETCH_EXECUTE: nextState = (faultCause != NONE) ? HALT : (isLoad ? EXECUTE : FETCH_EXECUTE);
			EXECUTE: nextState = (faultCause != NONE) ? HALT : FETCH_EXECUTE;
			default: nextState = HALT; // HALT spins, bad state halts
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			currentState <= INITIAL_WAIT;
			haltCause <= NONE;
		end
		else
		begin
			currentState <= nextState;
			if (faultCause != NONE)
				haltCause <= faultCause; // FSM leaves at once, so this is the first cause
		end
	end

	// Control lines per state
	always_comb
	begin
		controls = '0; // Wait and halt stay idle
		case (currentState)
			INITIAL_FETCH: controls.instructionAddressSource = CURRENT_PC; // Present PC once
			FETCH_EXECUTE: controls = decoded;
			EXECUTE:
			begin
				controls.rdWriteEnable = 1'b1; // Second half of lw
				controls.rdSource = MEMORY;
				controls.programCounterWriteEnable = 1'b1;
				controls.instructionAddressSource = NEXT_PC;
			end
			default: ;
		endcase
	end

	assign halted = (currentState == HALT);

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/1ps
`include "coreDefs.svh"

module executeUnit
	import corePkg::*;
(
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] programCounter,
	input logic [`XLEN-1:0] rs1Data,
	input logic [`XLEN-1:0] rs2Data,
	input Controls_t controls,
	input logic [`XLEN-1:0] loadData,
	output logic [`XLEN-1:0] rdData,
	output logic [`XLEN-1:0] dataAddress,
	output logic [`XLEN-1:0] nextProgramCounter,
	output logic branchTaken,
	output logic pcMisaligned
);

	logic [`XLEN-1:0] immediate;
	logic [`XLEN-1:0] aluOperand;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] pcPlusImmediate; // Branch, jal and auipc share this adder
	logic [`XLEN-1:0] sequentialPc;

	// Immediate former
	always_comb
	begin
		case (controls.immediateMode)
			I: immediate = {{20{instruction[31]}}, instruction[31:20]};
			S: immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
			B:
			begin
				immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
					instruction[30:25], instruction[11:8], 1'b0};
			end
			U: immediate = {instruction[31:12], 12'b0};
			J:
			begin
				immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
					instruction[20], instruction[30:21], 1'b0};
			end
			default: immediate = '0;
		endcase
	end

	assign aluOperand = controls.aluUseImmediate ? immediate : rs2Data;

	// ALU
	always_comb
	begin
		case (controls.aluOp)
			ADD: aluResult = rs1Data + aluOperand;
			SUB: aluResult = rs1Data - aluOperand;
			XOR: aluResult = rs1Data ^ aluOperand;
			OR: aluResult = rs1Data | aluOperand;
			AND: aluResult = rs1Data & aluOperand;
			default: aluResult = '0;
		endcase
	end

	assign dataAddress = aluResult; // lw and sw run rs1 + imm through the ALU

	assign pcPlusImmediate = programCounter + immediate;
	assign sequentialPc = programCounter + `XLEN'd4;

	// Control decides if the target is taken
	assign nextProgramCounter = controls.isBranch ? pcPlusImmediate : sequentialPc;
	assign pcMisaligned = (nextProgramCounter[1:0] != 2'b00);

	// beq on funct3 000, bne on 001
	assign branchTaken = (rs1Data == rs2Data) ^ instruction[12];

	// rd write-back mux
	always_comb
	begin
		case (controls.rdSource)
			ALU: rdData = aluResult;
			IMMEDIATE: rdData = immediate; // lui
			AUIPC_SUM: rdData = pcPlusImmediate;
			LINK: rdData = sequentialPc; // jal return address
			MEMORY: rdData = loadData;
			default: rdData = '0;
		endcase
	end

endmodule

//--- logic/memoryController.sv
`timescale 1ns/1ps
`include "coreDefs.svh"

module memoryController
	import corePkg::*;
(
	input logic clock,
	input logic reset,
	input Controls_t controls,
	input logic [`XLEN-1:0] address,
	input logic [`XLEN-1:0] storeData,
	output DataRequest_t dataRequest,
	input logic [`XLEN-1:0] readData,
	output logic [`XLEN-1:0] loadData,
	output logic dataMisaligned
);

	logic aligned;

	assign aligned = (address[1:0] == 2'b00); // Word accesses only

	// Misaligned access never reaches the bus
	assign dataRequest = '{
		address: address,
		writeData: storeData,
		read: controls.memoryRead & aligned,
		write: controls.memoryWrite & aligned
	};

	assign dataMisaligned = (controls.memoryRead | controls.memoryWrite) & ~aligned;

	// readData settles one edge after the request, before the cycle closes
	always_ff @(posedge clock)
	begin
		if (reset)
			loadData <= '0;
		else if (dataRequest.read)
			loadData <= readData; // Held for the EXECUTE write-back
	end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps
`include "coreDefs.svh"

module registerFile
(
	input logic clock,
	input logic reset,
	input logic [$clog2(`REG_COUNT)-1:0] rs1Index,
	input logic [$clog2(`REG_COUNT)-1:0] rs2Index,
	input logic [$clog2(`REG_COUNT)-1:0] rdIndex,
	input logic writeEnable,
	input logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data
);

	logic [`XLEN-1:0] registers [1:`REG_COUNT-1]; // x0 has no storage

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int index = 1; index < `REG_COUNT; index++)
				registers[index] <= '0;
		end
		else if (writeEnable && rdIndex != '0)
			registers[rdIndex] <= writeData; // Writes to x0 dropped
	end

	// Combinational reads, x0 hardwired
	assign rs1Data = (rs1Index == '0) ? '0 : registers[rs1Index];
	assign rs2Data = (rs2Index == '0) ? '0 : registers[rs2Index];

endmodule

//--- logic/riscvCore.sv
`timescale 1ns/1ps
`include "coreDefs.svh"

module riscvCore
	import corePkg::*;
(
	input logic clock,
	input logic reset,
	output logic [`XLEN-1:0] instructionAddress,
	input logic [31:0] instruction,
	output DataRequest_t dataRequest,
	input logic [`XLEN-1:0] readData,
	output logic halted,
	output HaltCause_t haltCause
);

	Controls_t controls;
	logic [`XLEN-1:0] programCounter;
	logic [`XLEN-1:0] nextProgramCounter;
	logic [`XLEN-1:0] rs1Data, rs2Data, rdData;
	logic [`XLEN-1:0] dataAddress;
	logic [`XLEN-1:0] loadData;
	logic branchTaken, pcMisaligned, dataMisaligned;

	// Program counter
	always_ff @(posedge clock)
	begin
		if (reset)
			programCounter <= `RESET_VECTOR;
		else if (controls.programCounterWriteEnable)
			programCounter <= nextProgramCounter;
	end

	// Fetch ahead with the next PC, or refetch the current one
	assign instructionAddress = (controls.instructionAddressSource == NEXT_PC) ?
		nextProgramCounter : programCounter;

	controlLogic control (.clock, .reset, .instruction, .branchTaken, .pcMisaligned,
		.dataMisaligned, .controls, .halted, .haltCause);

	// Fields straight from the instruction word
	registerFile registers (.clock, .reset, .rs1Index(instruction[19:15]),
		.rs2Index(instruction[24:20]), .rdIndex(instruction[11:7]),
		.writeEnable(controls.rdWriteEnable), .writeData(rdData), .rs1Data, .rs2Data);

	executeUnit execute (.instruction, .programCounter, .rs1Data, .rs2Data, .controls,
		.loadData, .rdData, .dataAddress, .nextProgramCounter, .branchTaken, .pcMisaligned);

	memoryController memory (.clock, .reset, .controls, .address(dataAddress),
		.storeData(rs2Data), .dataRequest, .readData, .loadData, .dataMisaligned);

endmodule

//--- test/coreProps.sv
`timescale 1ns/1ps

module coreProps
	import corePkg::*;
(
	input logic clock,
	input logic reset,
	input State_t currentState,
	input Controls_t controls,
	input logic halted
);

	int failureCount = 0; // Assertion failures so far

	// Halted core must stay quiet
	haltQuiet: assert property (@(posedge clock) disable iff (reset)
		currentState == HALT |-> !controls.memoryWrite && !controls.rdWriteEnable)
	else
	begin
		$error("memory or register write strobe active in HALT");
		failureCount++;
	end

	// HALT holds until reset
	haltedInHalt: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted && currentState == HALT)
	else
	begin
		$error("core left HALT without a reset");
		failureCount++;
	end

	// One data access per cycle
	singleAccess: assert property (@(posedge clock) disable iff (reset)
		!(controls.memoryRead && controls.memoryWrite))
	else
	begin
		$error("read and write requested together");
		failureCount++;
	end

	writeStates: assert property (@(posedge clock) disable iff (reset)
		controls.rdWriteEnable |-> currentState inside {FETCH_EXECUTE, EXECUTE})
	else
	begin
		$error("register write outside FETCH_EXECUTE and EXECUTE");
		failureCount++;
	end

endmodule

//--- test/coreTb.sv
`timescale 1ns/1ps
`include "coreDefs.svh"

module coreTb
	import corePkg::*;
();

	localparam logic [31:0] ECALL_WORD = 32'h00000073;

	logic clock;
	logic reset;
	logic [`XLEN-1:0] instructionAddress;
	logic [31:0] instruction = '0;
	DataRequest_t dataRequest;
	logic [`XLEN-1:0] readData = '0;
	logic halted;
	HaltCause_t haltCause;

	logic [31:0] memory [256]; // Shared by both ports, word addressed
	int programLength;
	int requestCount; // Data requests since the last reset
	logic [31:0] lfsrState = 32'hfc5;
	DataRequest_t expectedStores [$]; // From the reference ISS, in order
	string currentTest = "startup";

	riscvCore UUT (.clock, .reset, .instructionAddress, .instruction, .dataRequest, .readData,
		.halted, .haltCause);

	bind controlLogic coreProps controlChecks (.clock, .reset, .currentState, .controls, .halted);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Synchronous instruction RAM
	always @(posedge clock)
		instruction <= memory[instructionAddress[9:2]];

	// Data port answers on the falling edge inside the request cycle
	always @(negedge clock)
	begin
		if (dataRequest.read === 1'b1)
			readData <= memory[dataRequest.address[9:2]];
		if (dataRequest.write === 1'b1)
			memory[dataRequest.address[9:2]] = dataRequest.writeData;
	end

	task automatic abortRun();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic checkRequest(string name, DataRequest_t expected, DataRequest_t actual);
		if (expected.address !== actual.address || expected.writeData !== actual.writeData)
		begin
			$display("[FAIL] %s: expected store %h to %h, actual store %h to %h", name,
				expected.writeData, expected.address, actual.writeData, actual.address);
			abortRun();
		end
	endtask

	task automatic checkWord(string name, logic [`XLEN-1:0] expected, logic [`XLEN-1:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkCause(string name, HaltCause_t expected, HaltCause_t actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s: expected %s, actual %s", name, expected.name(), actual.name());
			abortRun();
		end
	endtask

	// Compare process, one expected store per observed write
	always @(negedge clock)
	begin
		if (UUT.control.controlChecks.failureCount != 0)
		begin
			$display("Error: %s: an assertion on the control outputs failed", currentTest);
			abortRun();
		end
		else
		begin
			if (dataRequest.read === 1'b1 || dataRequest.write === 1'b1)
				requestCount++;
			if (dataRequest.write === 1'b1)
			begin
				if (halted)
				begin
					$display("Error: %s: store issued while halted", currentTest);
					abortRun();
				end
				else if (expectedStores.size() == 0)
				begin
					$display("Error: %s: unexpected store to %h", currentTest, dataRequest.address);
					abortRun();
				end
				else
					checkRequest(currentTest, expectedStores.pop_front(), dataRequest);
			end
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] randomBits(int count);
		logic [31:0] value;
		value = '0;
		for (int bitIndex = 0; bitIndex < count; bitIndex++)
		begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return value;
	endfunction

	// Encoders per RV32I format
	function automatic logic [31:0] encodeI(Opcode_t opcode, logic [4:0] rd, logic [2:0] funct3,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic logic [31:0] encodeR(logic [6:0] funct7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] funct3, logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, OP};
	endfunction

	function automatic logic [31:0] encodeS(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE}; // sw
	endfunction

	function automatic logic [31:0] encodeB(logic [2:0] funct3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic logic [31:0] encodeU(Opcode_t opcode, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, opcode};
	endfunction

	function automatic logic [31:0] encodeJ(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	task automatic clearMemory();
		for (int index = 0; index < 256; index++)
			memory[index] = 32'hc0de0000 + index; // Unique word per address
		programLength = 0;
	endtask

	task automatic emit(logic [31:0] word);
		memory[programLength] = word;
		programLength++;
	endtask

	// Reference ISS on a copy of memory, fills expectedStores
	function automatic HaltCause_t referenceRun();
		logic [31:0] image [256];
		logic [31:0] regs [32];
		logic [31:0] pc, word, rs1Value, rs2Value, immediate, result, nextPc, address;
		logic writeRd;
		DataRequest_t store;
		image = memory;
		for (int index = 0; index < 32; index++)
			regs[index] = '0;
		pc = `RESET_VECTOR;
		for (int step = 0; step < 500; step++)
		begin
			word = image[pc[9:2]];
			rs1Value = regs[word[19:15]];
			rs2Value = regs[word[24:20]];
			immediate = {{20{word[31]}}, word[31:20]}; // I format by default
			result = '0;
			writeRd = 1'b0;
			nextPc = pc + 4;
			case (word[6:0])
				LUI:
				begin
					result = {word[31:12], 12'h000};
					writeRd = 1'b1;
				end
				AUIPC:
				begin
					result = pc + {word[31:12], 12'h000};
					writeRd = 1'b1;
				end
				OP_IMM:
				begin
					writeRd = 1'b1;
					case (word[14:12])
						3'b000: result = rs1Value + immediate;
						3'b100: result = rs1Value ^ immediate;
						3'b110: result = rs1Value | immediate;
						3'b111: result = rs1Value & immediate;
						default: return BAD_OPCODE;
					endcase
				end
				OP:
				begin
					writeRd = 1'b1;
					case ({word[31:25], word[14:12]})
						{7'h00, 3'b000}: result = rs1Value + rs2Value;
						{7'h20, 3'b000}: result = rs1Value - rs2Value;
						{7'h00, 3'b100}: result = rs1Value ^ rs2Value;
						{7'h00, 3'b110}: result = rs1Value | rs2Value;
						{7'h00, 3'b111}: result = rs1Value & rs2Value;
						default: return BAD_OPCODE;
					endcase
				end
				LOAD:
				begin
					address = rs1Value + immediate;
					if (word[14:12] != 3'b010)
						return BAD_OPCODE;
					if (address[1:0] != 2'b00)
						return DATA_MISALIGNED;
					result = image[address[9:2]];
					writeRd = 1'b1;
				end
				STORE:
				begin
					address = rs1Value + {{20{word[31]}}, word[31:25], word[11:7]};
					if (word[14:12] != 3'b010)
						return BAD_OPCODE;
					if (address[1:0] != 2'b00)
						return DATA_MISALIGNED;
					image[address[9:2]] = rs2Value;
					store = '{address: address, writeData: rs2Value, read: 1'b0, write: 1'b1};
					expectedStores.push_back(store);
				end
				BRANCH:
				begin
					if (word[14:13] != 2'b00)
						return BAD_OPCODE;
					// beq on equal, bne on unequal
					if ((word[14:12] == 3'b000) ? (rs1Value == rs2Value) : (rs1Value != rs2Value))
						nextPc = pc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
				end
				JAL:
				begin
					result = pc + 4;
					writeRd = 1'b1;
					nextPc = pc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
				end
				SYSTEM: return (word == ECALL_WORD) ? ECALL : BAD_OPCODE;
				default: return BAD_OPCODE;
			endcase
			if (nextPc[1:0] != 2'b00)
				return PC_MISALIGNED;
			if (writeRd && word[11:7] != 5'd0)
				regs[word[11:7]] = result;
			pc = nextPc;
		end
		return NONE; // Ran away without halting
	endfunction

	task automatic runProgram(string name, HaltCause_t intended);
		HaltCause_t issCause;
		int cycles;
		currentTest = name;
		expectedStores.delete();
		issCause = referenceRun();
		checkCause({name, " reference"}, intended, issCause);
		@(negedge clock);
		reset = 1'b1;
		requestCount = 0;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		checkCause({name, " after reset"}, NONE, haltCause);
		if (halted)
		begin
			$display("Error: %s: halted is high right after reset", name);
			abortRun();
		end
		// INITIAL_WAIT and INITIAL_FETCH issue no data request
		for (int step = 0; step < 2; step++)
		begin
			if (dataRequest.read || dataRequest.write)
			begin
				$display("Error: %s: data request before the first fetch", name);
				abortRun();
			end
			@(negedge clock);
		end
		cycles = 0;
		while (!halted && cycles < 2000)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!halted)
		begin
			$display("Error: %s: core never halted", name);
			abortRun();
		end
		repeat (3) @(negedge clock); // Window for stray writes after halt
		checkCause(name, issCause, haltCause);
		checkWord({name, " stores left"}, 32'd0, expectedStores.size());
	endtask

	initial
	begin
		reset = 1'b1;

		// Arithmetic with random immediates, x10 points at data
		clearMemory();
		emit(encodeI(OP_IMM, 10, 3'b000, 0, 12'h200));
		emit(encodeU(LUI, 1, randomBits(20)));
		emit(encodeU(AUIPC, 2, randomBits(20)));
		emit(encodeI(OP_IMM, 3, 3'b000, 1, randomBits(12)));
		emit(encodeI(OP_IMM, 4, 3'b100, 2, randomBits(12)));
		emit(encodeI(OP_IMM, 5, 3'b110, 3, randomBits(12)));
		emit(encodeI(OP_IMM, 6, 3'b111, 4, randomBits(12)));
		emit(encodeR(7'h00, 6, 5, 3'b000, 7)); // add
		emit(encodeR(7'h20, 1, 7, 3'b000, 8)); // sub
		for (int r = 1; r <= 8; r++)
			emit(encodeS(r, 10, 12'(4 * r)));
		emit(ECALL_WORD);
		runProgram("arithmetic", ECALL);

		// Store random words, reload them, x0 included
		clearMemory();
		memory[192] = randomBits(32); // Preloaded at 0x300
		emit(encodeI(OP_IMM, 10, 3'b000, 0, 12'h200));
		for (int k = 0; k < 4; k++)
		begin
			emit(encodeU(LUI, 1, randomBits(20)));
			emit(encodeI(OP_IMM, 1, 3'b000, 1, randomBits(12)));
			emit(encodeS(1, 10, 12'(4 * k)));
		end
		emit(encodeI(LOAD, 2, 3'b010, 10, 12'h000));
		emit(encodeI(LOAD, 0, 3'b010, 10, 12'h004));
		emit(encodeI(LOAD, 3, 3'b010, 10, 12'h008));
		emit(encodeI(LOAD, 4, 3'b010, 10, 12'h00c));
		emit(encodeI(LOAD, 5, 3'b010, 10, 12'h100));
		emit(encodeS(2, 10, 12'h040));
		emit(encodeS(0, 10, 12'h044));
		emit(encodeS(3, 10, 12'h048));
		emit(encodeS(4, 10, 12'h04c));
		emit(encodeS(5, 10, 12'h050));
		emit(ECALL_WORD);
		runProgram("load store", ECALL);

		// Branches taken and not taken, skipped stores must not appear
		clearMemory();
		emit(encodeI(OP_IMM, 1, 3'b000, 0, 12'd5));
		emit(encodeI(OP_IMM, 2, 3'b000, 0, 12'd5));
		emit(encodeI(OP_IMM, 3, 3'b000, 0, 12'd7));
		emit(encodeI(OP_IMM, 10, 3'b000, 0, 12'h200));
		emit(encodeB(3'b000, 1, 2, 13'd8)); // beq taken
		emit(encodeS(0, 10, 12'h000));
		emit(encodeB(3'b000, 1, 3, 13'd8)); // beq falls through
		emit(encodeS(1, 10, 12'h004));
		emit(encodeB(3'b001, 1, 3, 13'd8)); // bne taken
		emit(encodeS(3, 10, 12'h008));
		emit(encodeB(3'b001, 1, 2, 13'd8)); // bne falls through
		emit(encodeS(2, 10, 12'h00c));
		emit(encodeJ(5, 21'd8));
		emit(encodeS(3, 10, 12'h010));
		emit(encodeS(5, 10, 12'h014)); // Link value
		emit(ECALL_WORD);
		runProgram("control flow", ECALL);

		clearMemory();
		emit(encodeI(OP_IMM, 1, 3'b000, 0, 12'd1));
		emit(encodeI(OP_IMM, 10, 3'b000, 0, 12'h200));
		emit(encodeS(1, 10, 12'h000));
		emit(32'h0000000b); // custom-0, not implemented
		emit(encodeS(1, 10, 12'h004));
		emit(ECALL_WORD);
		runProgram("bad opcode", BAD_OPCODE);

		clearMemory();
		emit(encodeI(OP_IMM, 10, 3'b000, 0, 12'h202));
		emit(encodeI(LOAD, 1, 3'b010, 10, 12'h000));
		emit(encodeS(10, 0, 12'h200));
		emit(ECALL_WORD);
		runProgram("misaligned load", DATA_MISALIGNED);
		checkWord("misaligned load requests", 32'd0, requestCount);

		clearMemory();
		emit(encodeI(OP_IMM, 10, 3'b000, 0, 12'h200));
		emit(encodeJ(1, 21'd2)); // Target pc + 2
		emit(encodeS(1, 10, 12'h000));
		emit(ECALL_WORD);
		runProgram("misaligned jump", PC_MISALIGNED);

		if (UUT.control.controlChecks.failureCount != 0)
		begin
			$display("Error: an assertion on the control outputs failed");
			abortRun();
		end
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
